//--- bench/dcache_properties.sv
module dcache_properties (
  input logic                   clk,
  input logic                   resetn,
  input dcache_pkg::cpu_req_t   cpu_req,
  input logic                   addr_ok,
  input logic                   data_ok,
  input mem_bus_pkg::mem_req_t  mem_req,
  input mem_bus_pkg::mem_resp_t mem_resp,
  input dcache_pkg::state_t     state
);
  timeunit 1ns;
  timeprecision 1ps;
  import dcache_pkg::*;

  // one bus direction at a time
  a_rd_wr_excl: assert property (@(posedge clk) disable iff (!resetn)
    !(mem_req.rd_req && mem_req.wr_req))
    else $error("rd_req and wr_req high together");

  a_rd_hold: assert property (@(posedge clk) disable iff (!resetn)
    mem_req.rd_req && !mem_resp.rd_rdy |=> mem_req.rd_req && $stable(mem_req.rd_addr))
    else $error("read request dropped or moved before rd_rdy");

  a_wr_hold: assert property (@(posedge clk) disable iff (!resetn)
    mem_req.wr_req && !mem_resp.wr_rdy |=> mem_req.wr_req && $stable(mem_req.wr_addr))
    else $error("write request dropped or moved before wr_rdy");

  // an answer comes one cycle after its acceptance, or after the replay in idle
  a_answer_timing: assert property (@(posedge clk) disable iff (!resetn)
    data_ok |-> $past(cpu_req.valid && addr_ok) || $past(state) == S_IDLE)
    else $error("data_ok not one cycle after an accepted request");

endmodule

bind dcache_top dcache_properties i_props (
  .clk      (clk),
  .resetn   (resetn),
  .cpu_req  (cpu_req),
  .addr_ok  (addr_ok),
  .data_ok  (data_ok),
  .mem_req  (mem_req),
  .mem_resp (mem_resp),
  .state    (i_ctrl.state)
);

//--- bench/tb_dcache.sv
module tb_dcache;
  timeunit 1ns;
  timeprecision 1ps;
  import mem_bus_pkg::*;
  import dcache_pkg::*;

  localparam int N_OPS      = 300;
  localparam int CLK_PERIOD = 20;
  localparam int MEM_WORDS  = 512;  // tags 0..4 over all sets

  typedef struct packed {
    op_t         op;
    word         data;
    int unsigned cycle;  // acceptance cycle
    logic        fast;   // line known resident
  } expect_t;

  typedef enum logic [1:0] {M_IDLE, M_RET, M_ACK} mem_phase_t;

  logic        clk;
  logic        resetn;
  cpu_req_t    cpu_req;
  logic        addr_ok;
  logic        data_ok;
  word         rdata;
  mem_req_t    mem_req;
  mem_resp_t   mem_resp;

  integer      seed = 89968;
  word         backing [MEM_WORDS];  // memory behind the bus
  word         shadow [MEM_WORDS];   // what the CPU should see
  expect_t     exp_q [$];
  int unsigned cycle = 0;
  int unsigned rd_count = 0;
  int unsigned resp_count = 0;
  addr_t       last_addr;
  logic        have_last = 1'b0;
  index_t      busy_sets [3] = '{4'd2, 4'd9, 4'd13};
  mem_phase_t  mphase;
  int unsigned mdelay;
  addr_t       mline;

  dcache_top i_dut (
    .clk      (clk),
    .resetn   (resetn),
    .cpu_req  (cpu_req),
    .addr_ok  (addr_ok),
    .data_ok  (data_ok),
    .rdata    (rdata),
    .mem_req  (mem_req),
    .mem_resp (mem_resp)
  );

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1);
  endtask

  function automatic word fill_word(input addr_t a);
    return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h5ac3_0f17;
  endfunction

  function automatic int mem_index(input addr_t a, input int b);
    return {a[10:4], 2'b00} + b;
  endfunction

  function automatic line_t gather_line(input word m [MEM_WORDS], input addr_t a);
    line_t l;
    for (int b = 0; b < LINE_WORDS; b++) begin
      l[b*WORD_BITS +: WORD_BITS] = m[mem_index(a, b)];
    end
    return l;
  endfunction

  // reference: stores merge by strobe in acceptance order, loads read back
  function automatic word ref_access(input cpu_req_t r);
    int wi;
    wi = r.addr[10:2];
    if (r.op == OP_STORE) begin
      for (int k = 0; k < 4; k++) begin
        if (r.wstrb[k]) shadow[wi][8*k +: 8] = r.wdata[8*k +: 8];
      end
    end
    return shadow[wi];
  endfunction

  function automatic int unsigned rand_delay();
    return $unsigned($random(seed)) % 4;
  endfunction

  function automatic cpu_req_t random_req(input addr_t prev, input logic reuse);
    cpu_req_t r;
    r.valid = 1'b1;
    r.op    = ($random(seed) & 1) ? OP_STORE : OP_LOAD;
    if (reuse && ($random(seed) & 3) == 0) begin
      r.addr = {prev[31:4], 2'($random(seed)), 2'b00};  // same line again
    end else begin
      r.addr = {24'($unsigned($random(seed)) % 5), busy_sets[$unsigned($random(seed)) % 3],
                2'($random(seed)), 2'b00};
    end
    r.wstrb = 4'($random(seed));
    r.wdata = $random(seed);
    return r;
  endfunction

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  // memory model with 0 to 3 cycles on every rdy and valid
  always @(posedge clk) begin
    if (!resetn) begin
      mem_resp <= '0;
      mphase   <= M_IDLE;
      mdelay   <= 0;
    end else begin
      mem_resp.rd_rdy    <= 1'b0;
      mem_resp.wr_rdy    <= 1'b0;
      mem_resp.ret_valid <= 1'b0;
      mem_resp.wr_valid  <= 1'b0;
      case (mphase)
        M_IDLE: begin
          if (mem_req.rd_req || mem_req.wr_req) begin
            if (mdelay != 0) begin
              mdelay <= mdelay - 1;
            end else if (mem_req.rd_req) begin
              mem_resp.rd_rdy <= 1'b1;
              mline    <= mem_req.rd_addr;
              rd_count <= rd_count + 1;
              mphase   <= M_RET;
              mdelay   <= rand_delay();
            end else begin
              assert (mem_req.wr_addr[3:0] == 4'h0) else report_failure($sformatf(
                "[FAIL] wr_addr[3:0]: got %h, expected %h", mem_req.wr_addr[3:0], 4'h0));
              assert (mem_req.wr_data === gather_line(shadow, mem_req.wr_addr))
                else report_failure($sformatf("[FAIL] wr_data: got %h, expected %h",
                mem_req.wr_data, gather_line(shadow, mem_req.wr_addr)));
              for (int b = 0; b < LINE_WORDS; b++) begin
                backing[mem_index(mem_req.wr_addr, b)] = mem_req.wr_data[b*WORD_BITS +: WORD_BITS];
              end
              mem_resp.wr_rdy <= 1'b1;
              mphase <= M_ACK;
              mdelay <= rand_delay();
            end
          end
        end
        M_RET: begin
          if (mdelay != 0) begin
            mdelay <= mdelay - 1;
          end else begin
            mem_resp.ret_valid <= 1'b1;
            mem_resp.ret_data  <= gather_line(backing, mline);
            mphase <= M_IDLE;
            mdelay <= rand_delay();
          end
        end
        default: begin  // waiting to confirm the write
          if (mdelay != 0) begin
            mdelay <= mdelay - 1;
          end else begin
            mem_resp.wr_valid <= 1'b1;
            mphase <= M_IDLE;
            mdelay <= rand_delay();
          end
        end
      endcase
    end
  end

  // comparison of responses, then capture of new acceptances
  always @(posedge clk) begin
    expect_t e;
    if (resetn) begin
      if (data_ok) begin
        assert (exp_q.size() > 0) else report_failure("data_ok came with no request pending");
        e = exp_q.pop_front();
        if (e.op == OP_LOAD) begin
          assert (rdata === e.data)
            else report_failure($sformatf("[FAIL] rdata: got %h, expected %h", rdata, e.data));
        end
        if (e.fast) begin
          assert (cycle - e.cycle == 1) else report_failure($sformatf(
            "[FAIL] data_ok latency: got %h, expected %h", cycle - e.cycle, 1));
        end
        if (resp_count == 0) begin
          assert (rd_count > 0) else report_failure("first request answered without a refill");
        end
        resp_count++;
      end
      if (cpu_req.valid && addr_ok) begin
        e.op    = cpu_req.op;
        e.data  = ref_access(cpu_req);
        e.cycle = cycle;
        e.fast  = cpu_req.op == OP_LOAD && have_last && cpu_req.addr[31:4] == last_addr[31:4];
        last_addr = cpu_req.addr;
        have_last = 1'b1;
        exp_q.push_back(e);
      end
    end
  end

  initial begin
    cpu_req_t next;
    addr_t    prev;
    cpu_req  = '0;
    mem_resp = '0;
    resetn   = 1'b0;
    prev     = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      backing[i] = fill_word(addr_t'(i * 4));
      shadow[i]  = backing[i];
    end
    repeat (3) @(posedge clk);
    resetn <= 1'b1;
    @(posedge clk);
    assert (!data_ok && !mem_req.rd_req && !mem_req.wr_req && addr_ok)
      else report_failure($sformatf("[FAIL] after reset data_ok %h rd_req %h wr_req %h addr_ok %h",
        data_ok, mem_req.rd_req, mem_req.wr_req, addr_ok));
    for (int n = 0; n < N_OPS; n++) begin
      if (($random(seed) & 7) == 0) begin
        cpu_req.valid <= 1'b0;  // idle gap
        @(posedge clk);
      end
      next = random_req(prev, n > 0);
      prev = next.addr;
      cpu_req <= next;
      @(posedge clk);
      while (!addr_ok) @(posedge clk);
    end
    cpu_req <= '0;
    while (resp_count != N_OPS) @(posedge clk);
    @(posedge clk);
    if (exp_q.size() == 0 && resp_count == N_OPS) begin
      $display("No errors");
      $finish;
    end else begin
      report_failure($sformatf("[FAIL] resp_count: got %h, expected %h", resp_count, N_OPS));
    end
  end

  // watchdog sized on the op count
  initial begin
    #(N_OPS * 40 * CLK_PERIOD);
    report_failure("timeout, the cache stopped answering requests");
  end

endmodule

//--- flist.f
source/mem_bus_pkg.sv
source/dcache_pkg.sv
source/dcache_arrays.sv
source/dcache_replace.sv
source/dcache_ctrl.sv
source/dcache_top.sv
bench/dcache_properties.sv
bench/tb_dcache.sv

//--- source/dcache_arrays.sv
module dcache_arrays (
  input  logic                   clk,
  input  logic                   resetn,
  input  logic                   rd_en,
  input  dcache_pkg::index_t     rd_index,
  input  dcache_pkg::array_wr_t  wr,
  output dcache_pkg::way_tags_t  tags,
  output dcache_pkg::way_lines_t lines
);
  import mem_bus_pkg::*;
  import dcache_pkg::*;

  logic [SETS-1:0] valid_q [WAYS];
  tag_t            tag_mem [WAYS][SETS];
  word             data_mem [WAYS][LINE_WORDS][SETS];  // one bank per word

  always_ff @(posedge clk) begin
    if (!resetn) begin
      for (int w = 0; w < WAYS; w++) begin
        valid_q[w] <= '0;
      end
    end else if (wr.tag_we) begin
      valid_q[wr.way][wr.index] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr.tag_we) begin
      tag_mem[wr.way][wr.index] <= wr.tag;
    end
  end

  // refill fills every bank, a store touches its strobed bytes only
  always_ff @(posedge clk) begin
    if (wr.line_we) begin
      for (int b = 0; b < LINE_WORDS; b++) begin
        data_mem[wr.way][b][wr.index] <= wr.line[b*WORD_BITS +: WORD_BITS];
      end
    end else begin
      for (int k = 0; k < WORD_BITS / 8; k++) begin
        if (wr.wstrb[k]) begin
          data_mem[wr.way][wr.word_sel][wr.index][8*k +: 8] <= wr.word[8*k +: 8];
        end
      end
    end
  end

  // registered read, holds while rd_en is low
  always_ff @(posedge clk) begin
    if (rd_en) begin
      for (int w = 0; w < WAYS; w++) begin
        tags[w].valid <= valid_q[w][rd_index];
        tags[w].tag   <= tag_mem[w][rd_index];
        for (int b = 0; b < LINE_WORDS; b++) begin
          lines[w][b*WORD_BITS +: WORD_BITS] <= data_mem[w][b][rd_index];
        end
      end
    end
  end

endmodule

//--- source/dcache_ctrl.sv
module dcache_ctrl (
  input  logic                   clk,
  input  logic                   resetn,
  input  dcache_pkg::cpu_req_t   cpu_req,
  output logic                   addr_ok,
  output logic                   data_ok,
  output mem_bus_pkg::word       rdata,
  output mem_bus_pkg::mem_req_t  mem_req,
  input  mem_bus_pkg::mem_resp_t mem_resp,
  output logic                   rd_en,
  output dcache_pkg::index_t     rd_index,
  output dcache_pkg::array_wr_t  wr,
  input  dcache_pkg::way_tags_t  tags,
  input  dcache_pkg::way_lines_t lines,
  output dcache_pkg::index_t     repl_index,
  output logic                   touch_valid,
  output dcache_pkg::way_t       touch_way,
  output logic                   touch_store,
  output logic                   clean_valid,
  input  dcache_pkg::way_t       victim_way,
  input  logic                   victim_dirty
);
  import mem_bus_pkg::*;
  import dcache_pkg::*;

  typedef struct packed {
    way_t       way;
    index_t     index;
    bank_t      bank;
    logic [3:0] wstrb;
    word        data;
  } store_buf_t;

  state_t          state;
  state_t          state_nxt;
  cpu_req_t        req_buf;
  store_buf_t      stb;
  logic            replay;   // refill done, look the buffered request up again
  logic            accept;
  logic [WAYS-1:0] hit_way;
  logic            hit;
  way_t            hit_sel;
  index_t          buf_index;
  tag_t            buf_tag;
  bank_t           buf_bank;

  assign buf_index = req_buf.addr[OFFSET_BITS +: INDEX_BITS];
  assign buf_tag   = req_buf.addr[OFFSET_BITS+INDEX_BITS +: TAG_BITS];
  assign buf_bank  = req_buf.addr[2 +: BANK_BITS];

  // tags come back one cycle after the read, same cycle as req_buf
  always_comb begin
    for (int w = 0; w < WAYS; w++) begin
      hit_way[w] = tags[w].valid && (tags[w].tag == buf_tag);
    end
  end

  assign hit     = |hit_way;
  assign hit_sel = hit_way[1];

  assign data_ok = (state == S_LOOKUP) && hit;
  assign rdata   = lines[hit_sel][buf_bank*WORD_BITS +: WORD_BITS];
  // load hits keep the pipe open, stores close it for two cycles
  assign addr_ok = ((state == S_IDLE) && !replay) || (data_ok && req_buf.op == OP_LOAD);
  assign accept  = cpu_req.valid && addr_ok;

  assign rd_en    = accept || ((state == S_IDLE) && replay);
  assign rd_index = replay ? buf_index : cpu_req.addr[OFFSET_BITS +: INDEX_BITS];

  assign repl_index  = buf_index;
  assign touch_valid = data_ok;
  assign touch_way   = hit_sel;
  assign touch_store = req_buf.op == OP_STORE;
  assign clean_valid = (state == S_WRITEBACK) && mem_resp.wr_valid;

  always_ff @(posedge clk) begin
    if (accept) begin
      req_buf <= cpu_req;
    end
  end

  always_ff @(posedge clk) begin
    if (data_ok && req_buf.op == OP_STORE) begin
      stb.way   <= hit_sel;
      stb.index <= buf_index;
      stb.bank  <= buf_bank;
      stb.wstrb <= req_buf.wstrb;
      stb.data  <= req_buf.wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state  <= S_IDLE;
      replay <= 1'b0;
    end else begin
      state <= state_nxt;
      if (state == S_REFILL && mem_resp.ret_valid) begin
        replay <= 1'b1;
      end else if (state == S_IDLE) begin
        replay <= 1'b0;
      end
    end
  end

  always_comb begin
    state_nxt = state;
    unique case (state)
      S_IDLE: begin
        if (replay || accept) begin
          state_nxt = S_LOOKUP;
        end
      end
      S_LOOKUP: begin
        if (!hit) begin
          state_nxt = victim_dirty ? S_MISS_DIRTY : S_MISS_CLEAN;
        end else if (req_buf.op == OP_STORE) begin
          state_nxt = S_STORE;
        end else if (!accept) begin
          state_nxt = S_IDLE;
        end
      end
      S_STORE: begin
        state_nxt = S_IDLE;
      end
      S_MISS_DIRTY: begin
        if (mem_resp.wr_rdy) begin
          state_nxt = S_WRITEBACK;
        end
      end
      S_WRITEBACK: begin
        if (mem_resp.wr_valid) begin
          state_nxt = S_MISS_CLEAN;
        end
      end
      S_MISS_CLEAN: begin
        if (mem_resp.rd_rdy) begin
          state_nxt = S_REFILL;
        end
      end
      S_REFILL: begin
        if (mem_resp.ret_valid) begin
          state_nxt = S_IDLE;
        end
      end
      default: begin
        state_nxt = S_IDLE;
      end
    endcase
  end

  // array outputs still hold the miss lookup, victim tag and line included
  always_comb begin
    mem_req         = '0;
    mem_req.rd_req  = state == S_MISS_CLEAN;
    mem_req.rd_addr = {buf_tag, buf_index, {OFFSET_BITS{1'b0}}};
    mem_req.wr_req  = state == S_MISS_DIRTY;
    mem_req.wr_addr = {tags[victim_way].tag, buf_index, {OFFSET_BITS{1'b0}}};
    mem_req.wr_data = lines[victim_way];
  end

  always_comb begin
    wr = '0;
    if (state == S_REFILL && mem_resp.ret_valid) begin
      wr.way     = victim_way;
      wr.index   = buf_index;
      wr.tag_we  = 1'b1;
      wr.tag     = buf_tag;
      wr.line_we = 1'b1;
      wr.line    = mem_resp.ret_data;
    end else if (state == S_STORE) begin
      wr.way      = stb.way;
      wr.index    = stb.index;
      wr.word_sel = stb.bank;
      wr.wstrb    = stb.wstrb;
      wr.word     = stb.data;
    end
  end

endmodule

//--- source/dcache_pkg.sv
package dcache_pkg;

  localparam int WAYS        = 2;
  localparam int SETS        = 16;
  localparam int OFFSET_BITS = 4;
  localparam int INDEX_BITS  = 4;
  localparam int TAG_BITS    = 24;
  localparam int BANK_BITS   = 2;  // word select inside a line

  typedef logic [INDEX_BITS-1:0] index_t;
  typedef logic [TAG_BITS-1:0]   tag_t;
  typedef logic [BANK_BITS-1:0]  bank_t;
  typedef logic                  way_t;

  typedef enum logic {
    OP_LOAD  = 1'b0,
    OP_STORE = 1'b1
  } op_t;

  typedef struct packed {
    logic               valid;
    op_t                op;
    mem_bus_pkg::addr_t addr;
    logic [3:0]         wstrb;  // bytes already in place
    mem_bus_pkg::word   wdata;
  } cpu_req_t;

  typedef struct packed {
    way_t               way;
    index_t             index;
    logic               tag_we;   // sets valid as well
    tag_t               tag;
    logic               line_we;
    bank_t              word_sel;
    logic [3:0]         wstrb;    // nonzero means a single word write
    mem_bus_pkg::word   word;
    mem_bus_pkg::line_t line;
  } array_wr_t;

  typedef struct packed {
    logic valid;
    tag_t tag;
  } tag_entry_t;

  typedef tag_entry_t [WAYS-1:0]         way_tags_t;
  typedef mem_bus_pkg::line_t [WAYS-1:0] way_lines_t;

  typedef enum logic [2:0] {
    S_IDLE,
    S_LOOKUP,
    S_STORE,
    S_MISS_CLEAN,
    S_MISS_DIRTY,
    S_WRITEBACK,
    S_REFILL
  } state_t;

endpackage

//--- source/dcache_replace.sv
module dcache_replace (
  input  logic               clk,
  input  logic               resetn,
  input  dcache_pkg::index_t index,
  input  logic               touch_valid,
  input  dcache_pkg::way_t   touch_way,
  input  logic               touch_store,
  input  logic               clean_valid,
  output dcache_pkg::way_t   victim_way,
  output logic               victim_dirty
);
  import dcache_pkg::*;

  logic [SETS-1:0] lru_q;             // bit names the way to evict next
  logic [SETS-1:0] dirty_q [WAYS];

  assign victim_way   = lru_q[index];
  assign victim_dirty = dirty_q[victim_way][index];

  always_ff @(posedge clk) begin
    if (!resetn) begin
      lru_q <= '0;
    end else if (touch_valid) begin
      lru_q[index] <= ~touch_way;  // other way becomes the victim
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      for (int w = 0; w < WAYS; w++) begin
        dirty_q[w] <= '0;
      end
    end else if (touch_valid && touch_store) begin
      dirty_q[touch_way][index] <= 1'b1;
    end else if (clean_valid) begin
      // victim just went out to memory
      dirty_q[victim_way][index] <= 1'b0;
    end
  end

endmodule

//--- source/dcache_top.sv
module dcache_top (
  input  logic                   clk,
  input  logic                   resetn,
  input  dcache_pkg::cpu_req_t   cpu_req,
  output logic                   addr_ok,
  output logic                   data_ok,
  output mem_bus_pkg::word       rdata,
  output mem_bus_pkg::mem_req_t  mem_req,
  input  mem_bus_pkg::mem_resp_t mem_resp
);
  import dcache_pkg::*;

  logic       rd_en;
  index_t     rd_index;
  array_wr_t  wr;
  way_tags_t  tags;
  way_lines_t lines;
  index_t     repl_index;
  logic       touch_valid;
  way_t       touch_way;
  logic       touch_store;
  logic       clean_valid;
  way_t       victim_way;
  logic       victim_dirty;

  dcache_ctrl i_ctrl (
    .clk          (clk),
    .resetn       (resetn),
    .cpu_req      (cpu_req),
    .addr_ok      (addr_ok),
    .data_ok      (data_ok),
    .rdata        (rdata),
    .mem_req      (mem_req),
    .mem_resp     (mem_resp),
    .rd_en        (rd_en),
    .rd_index     (rd_index),
    .wr           (wr),
    .tags         (tags),
    .lines        (lines),
    .repl_index   (repl_index),
    .touch_valid  (touch_valid),
    .touch_way    (touch_way),
    .touch_store  (touch_store),
    .clean_valid  (clean_valid),
    .victim_way   (victim_way),
    .victim_dirty (victim_dirty)
  );

  dcache_arrays i_arrays (
    .clk      (clk),
    .resetn   (resetn),
    .rd_en    (rd_en),
    .rd_index (rd_index),
    .wr       (wr),
    .tags     (tags),
    .lines    (lines)
  );

  // victim choice follows the buffered request's set
  dcache_replace i_replace (
    .clk          (clk),
    .resetn       (resetn),
    .index        (repl_index),
    .touch_valid  (touch_valid),
    .touch_way    (touch_way),
    .touch_store  (touch_store),
    .clean_valid  (clean_valid),
    .victim_way   (victim_way),
    .victim_dirty (victim_dirty)
  );

endmodule

//--- source/mem_bus_pkg.sv
package mem_bus_pkg;

  localparam int ADDR_BITS  = 32;
  localparam int WORD_BITS  = 32;
  localparam int LINE_WORDS = 4;
  localparam int LINE_BITS  = LINE_WORDS * WORD_BITS;

  typedef logic [ADDR_BITS-1:0] addr_t;
  typedef logic [WORD_BITS-1:0] word;
  typedef logic [LINE_BITS-1:0] line_t;  // word 0 in the low bits

  typedef struct packed {
    logic  rd_req;
    addr_t rd_addr;   // line aligned
    logic  wr_req;
    addr_t wr_addr;   // line aligned
    line_t wr_data;
  } mem_req_t;

  typedef struct packed {
    logic  rd_rdy;
    logic  wr_rdy;
    logic  ret_valid;
    line_t ret_data;
    logic  wr_valid;  // write committed
  } mem_resp_t;

endpackage
